//--- rv_sys_pkg.sv
package rv_sys_pkg;

    // data, pc and addresses share one width
    typedef logic [31:0] word_t;

    typedef enum logic {
        size_byte,
        size_word
    } acc_size_t;

    localparam word_t boot_default = 32'h80000000;

    // multi-cycle control states
    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_exec,
        st_load,
        st_retire,
        st_halt
    } core_state_t;

endpackage

//--- rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes of the supported subset
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_system = 7'b1110011;

    // ebreak is matched on the whole word
    localparam logic [31:0] ebreak_word = 32'h00100073;

    typedef logic [4:0] reg_idx_t;

    typedef enum logic [3:0] {
        kind_lui,
        kind_auipc,
        kind_jal,
        kind_jalr,
        kind_addi,
        kind_add,
        kind_lw,
        kind_lbu,
        kind_ebreak,
        kind_none
    } inst_kind_t;

    // write-back source
    typedef enum logic [1:0] {
        res_adder,
        res_pc4,
        res_imm,
        res_load
    } res_sel_t;

    typedef struct packed {
        inst_kind_t  kind;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [31:0] imm;
        logic        reg_wen;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        is_load;
        logic        is_byte;
        res_sel_t    res_sel;
    } decoded_t;

endpackage

//--- mem_access_if.sv
`timescale 1ns/10ps

interface mem_access_if;

    // request side held stable until done
    logic                  start;
    rv_sys_pkg::word_t     addr;
    rv_sys_pkg::acc_size_t size;
    // one-cycle completion pulse with its data
    logic                  done;
    rv_sys_pkg::word_t     rdata;

    modport ctrl (
        output start,
        output addr,
        output size,
        input  done,
        input  rdata
    );

    modport bridge (
        input  start,
        input  addr,
        input  size,
        output done,
        output rdata
    );

endinterface

//--- inst_decode.sv
`timescale 1ns/10ps

module inst_decode (
    input  rv_sys_pkg::word_t    inst,
    output rv_isa_pkg::decoded_t dec
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    rv_sys_pkg::word_t      imm_i;
    rv_sys_pkg::word_t      imm_u;
    rv_sys_pkg::word_t      imm_j;
    rv_isa_pkg::inst_kind_t kind;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // i and j immediates sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // opcode plus funct3 picks the kind
    always_comb begin
        kind = rv_isa_pkg::kind_none;
        case (opcode)
            rv_isa_pkg::op_lui:   kind = rv_isa_pkg::kind_lui;
            rv_isa_pkg::op_auipc: kind = rv_isa_pkg::kind_auipc;
            rv_isa_pkg::op_jal:   kind = rv_isa_pkg::kind_jal;
            rv_isa_pkg::op_jalr: begin
                if (funct3 == 3'b000)
                    kind = rv_isa_pkg::kind_jalr;
            end
            rv_isa_pkg::op_imm: begin
                if (funct3 == 3'b000)
                    kind = rv_isa_pkg::kind_addi;
            end
            rv_isa_pkg::op_reg: begin
                // sub shares funct3, so funct7 must be zero
                if (funct3 == 3'b000 && funct7 == 7'b0)
                    kind = rv_isa_pkg::kind_add;
            end
            rv_isa_pkg::op_load: begin
                if (funct3 == 3'b010)
                    kind = rv_isa_pkg::kind_lw;
                else if (funct3 == 3'b100)
                    kind = rv_isa_pkg::kind_lbu;
            end
            rv_isa_pkg::op_system: begin
                if (inst == rv_isa_pkg::ebreak_word)
                    kind = rv_isa_pkg::kind_ebreak;
            end
            default: kind = rv_isa_pkg::kind_none;
        endcase
    end

    always_comb begin
        dec.kind = kind;
        dec.rd   = inst[11:7];
        dec.rs1  = inst[19:15];
        dec.rs2  = inst[24:20];
        // immediate chosen by format
        case (opcode)
            rv_isa_pkg::op_lui,
            rv_isa_pkg::op_auipc: dec.imm = imm_u;
            rv_isa_pkg::op_jal:   dec.imm = imm_j;
            rv_isa_pkg::op_jalr,
            rv_isa_pkg::op_imm,
            rv_isa_pkg::op_load:  dec.imm = imm_i;
            default:              dec.imm = '0;
        endcase
        // unknown kinds and ebreak write nothing
        dec.reg_wen = !(kind inside {rv_isa_pkg::kind_none, rv_isa_pkg::kind_ebreak});
        // jal reuses the adder as pc + imm
        dec.src1_is_pc  = kind inside {rv_isa_pkg::kind_auipc, rv_isa_pkg::kind_jal};
        dec.src2_is_imm = !(kind inside {rv_isa_pkg::kind_add, rv_isa_pkg::kind_lui});
        dec.is_load     = kind inside {rv_isa_pkg::kind_lw, rv_isa_pkg::kind_lbu};
        dec.is_byte     = (kind == rv_isa_pkg::kind_lbu);
        if (dec.is_load)
            dec.res_sel = rv_isa_pkg::res_load;
        else if (kind inside {rv_isa_pkg::kind_jal, rv_isa_pkg::kind_jalr})
            dec.res_sel = rv_isa_pkg::res_pc4;
        else if (kind == rv_isa_pkg::kind_lui)
            dec.res_sel = rv_isa_pkg::res_imm;
        else
            dec.res_sel = rv_isa_pkg::res_adder;
    end

endmodule

//--- regfile.sv
`timescale 1ns/10ps

module regfile #(
    parameter int num_regs = 32
) (
    input  logic                 clk,
    input  logic                 wen,
    input  rv_isa_pkg::reg_idx_t waddr,
    input  rv_isa_pkg::reg_idx_t raddr1,
    input  rv_isa_pkg::reg_idx_t raddr2,
    input  rv_sys_pkg::word_t    wdata,
    output rv_sys_pkg::word_t    rdata1,
    output rv_sys_pkg::word_t    rdata2
);

    localparam int idx_w = $clog2(num_regs);

    rv_sys_pkg::word_t regs [num_regs];
    logic [idx_w-1:0]  widx;
    logic [idx_w-1:0]  ridx1;
    logic [idx_w-1:0]  ridx2;

    // upper index bits dropped, so indices wrap
    assign widx  = waddr[idx_w-1:0];
    assign ridx1 = raddr1[idx_w-1:0];
    assign ridx2 = raddr2[idx_w-1:0];

    // x0 never written
    always_ff @(posedge clk) begin
        if (wen && widx != '0)
            regs[widx] <= wdata;
    end

    assign rdata1 = (ridx1 == '0) ? '0 : regs[ridx1];
    assign rdata2 = (ridx2 == '0) ? '0 : regs[ridx2];

endmodule

//--- core_ctrl.sv
`timescale 1ns/10ps

module core_ctrl #(
    parameter int num_regs = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_sys_pkg::word_t    boot_pc,
    input  logic                 go,
    mem_access_if.ctrl           mem,
    output logic                 retire_valid,
    output rv_sys_pkg::word_t    retire_pc,
    output rv_isa_pkg::reg_idx_t retire_rd,
    output rv_sys_pkg::word_t    retire_data,
    output logic                 ebreak_hit
);

    rv_sys_pkg::core_state_t state;
    rv_sys_pkg::word_t       pc;
    rv_sys_pkg::word_t       ir;
    rv_sys_pkg::word_t       ld_data;
    rv_isa_pkg::decoded_t    dec;
    rv_sys_pkg::word_t       rs1_val;
    rv_sys_pkg::word_t       rs2_val;
    rv_sys_pkg::word_t       op1;
    rv_sys_pkg::word_t       op2;
    rv_sys_pkg::word_t       sum;
    rv_sys_pkg::word_t       pc4;
    rv_sys_pkg::word_t       next_pc;
    rv_sys_pkg::word_t       ld_val;
    rv_sys_pkg::word_t       wb_data;
    logic                    wen;

    inst_decode dec_i (
        .inst (ir),
        .dec  (dec)
    );

    regfile #(
        .num_regs (num_regs)
    ) rf_i (
        .clk    (clk),
        .wen    (wen),
        .waddr  (dec.rd),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .wdata  (wb_data),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    // operand muxes and the single adder
    assign op1 = dec.src1_is_pc  ? pc      : rs1_val;
    assign op2 = dec.src2_is_imm ? dec.imm : rs2_val;
    assign sum = op1 + op2;
    assign pc4 = pc + 32'd4;

    // jal sum is already pc + imm
    always_comb begin
        case (dec.kind)
            rv_isa_pkg::kind_jalr: next_pc = {sum[31:1], 1'b0};
            rv_isa_pkg::kind_jal:  next_pc = sum;
            default:               next_pc = pc4;
        endcase
    end

    // bridge returns bytes in bits 7:0
    assign ld_val = dec.is_byte ? {24'b0, ld_data[7:0]} : ld_data;

    always_comb begin
        case (dec.res_sel)
            rv_isa_pkg::res_pc4:  wb_data = pc4;
            rv_isa_pkg::res_imm:  wb_data = dec.imm;
            rv_isa_pkg::res_load: wb_data = ld_val;
            default:              wb_data = sum;
        endcase
    end

    // load address is rs1 + imm and fetch uses pc
    assign mem.start = (state == rv_sys_pkg::st_fetch) || (state == rv_sys_pkg::st_load);
    assign mem.addr  = (state == rv_sys_pkg::st_load) ? sum : pc;
    assign mem.size  = (state == rv_sys_pkg::st_load && dec.is_byte) ?
                       rv_sys_pkg::size_byte : rv_sys_pkg::size_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rv_sys_pkg::st_idle;
            pc    <= rv_sys_pkg::boot_default;
        end else if (go) begin
            case (state)
                rv_sys_pkg::st_idle: begin
                    pc    <= boot_pc;
                    state <= rv_sys_pkg::st_fetch;
                end
                rv_sys_pkg::st_fetch: begin
                    if (mem.done)
                        state <= rv_sys_pkg::st_exec;
                end
                rv_sys_pkg::st_exec: begin
                    state <= dec.is_load ? rv_sys_pkg::st_load : rv_sys_pkg::st_retire;
                end
                rv_sys_pkg::st_load: begin
                    if (mem.done)
                        state <= rv_sys_pkg::st_retire;
                end
                rv_sys_pkg::st_retire: begin
                    pc    <= next_pc;
                    state <= (dec.kind == rv_isa_pkg::kind_ebreak) ?
                             rv_sys_pkg::st_halt : rv_sys_pkg::st_fetch;
                end
                default: state <= rv_sys_pkg::st_halt;
            endcase
        end
    end

    // instruction and load data captured on done
    always_ff @(posedge clk) begin
        if (state == rv_sys_pkg::st_fetch && mem.done)
            ir <= mem.rdata;
        if (state == rv_sys_pkg::st_load && mem.done)
            ld_data <= mem.rdata;
    end

    // retire is the only write cycle
    assign retire_valid = (state == rv_sys_pkg::st_retire);
    assign wen          = retire_valid && dec.reg_wen;
    assign ebreak_hit   = retire_valid && (dec.kind == rv_isa_pkg::kind_ebreak);
    assign retire_pc    = pc;
    assign retire_rd    = dec.reg_wen ? dec.rd : '0;
    assign retire_data  = dec.reg_wen ? wb_data : '0;

endmodule

//--- bus_bridge.sv
`timescale 1ns/10ps

module bus_bridge (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mem_ack,
    input  rv_sys_pkg::word_t     mem_rdata,
    mem_access_if.bridge          acc,
    output logic                  mem_req,
    output rv_sys_pkg::word_t     mem_addr,
    output rv_sys_pkg::acc_size_t mem_size
);

    typedef enum logic [1:0] {
        br_idle,
        br_wait_hi,
        br_wait_lo,
        br_done
    } br_state_t;

    br_state_t         state;
    rv_sys_pkg::word_t rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= br_idle;
            mem_req <= 1'b0;
        end else begin
            case (state)
                br_idle: begin
                    if (acc.start) begin
                        mem_req <= 1'b1;
                        state   <= br_wait_hi;
                    end
                end
                // drop req as soon as ack arrives
                br_wait_hi: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= br_wait_lo;
                    end
                end
                br_wait_lo: begin
                    if (!mem_ack)
                        state <= br_done;
                end
                default: state <= br_idle;
            endcase
        end
    end

    // address, size and data held over the handshake
    always_ff @(posedge clk) begin
        if (state == br_idle && acc.start) begin
            mem_addr <= acc.addr;
            mem_size <= acc.size;
        end
        if (state == br_wait_hi && mem_ack)
            rdata_q <= mem_rdata;
    end

    assign acc.done  = (state == br_done);
    assign acc.rdata = rdata_q;

endmodule

//--- run_cfg.sv
`timescale 1ns/10ps

module run_cfg (
    input  logic              clk,
    input  logic              reset,
    input  rv_sys_pkg::word_t boot_addr,
    input  logic              retire,
    input  logic              ebreak_hit,
    output rv_sys_pkg::word_t boot_pc,
    output logic              go,
    output logic              halted,
    output rv_sys_pkg::word_t instret
);

    logic halted_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            // boot address sampled for the whole reset
            boot_pc  <= boot_addr;
            halted_q <= 1'b0;
            instret  <= '0;
        end else begin
            if (ebreak_hit)
                halted_q <= 1'b1;
            // ebreak counts as a retire too
            if (retire)
                instret <= instret + 32'd1;
        end
    end

    // core keeps stepping through the ebreak retire
    assign go     = !halted_q;
    assign halted = halted_q || ebreak_hit;

endmodule

//--- rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top #(
    parameter int num_regs = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_sys_pkg::word_t     boot_addr,
    input  logic                  mem_ack,
    input  rv_sys_pkg::word_t     mem_rdata,
    output logic                  mem_req,
    output rv_sys_pkg::word_t     mem_addr,
    output rv_sys_pkg::acc_size_t mem_size,
    output logic                  retire_valid,
    output rv_sys_pkg::word_t     retire_pc,
    output rv_isa_pkg::reg_idx_t  retire_rd,
    output rv_sys_pkg::word_t     retire_data,
    output logic                  halted,
    output rv_sys_pkg::word_t     instret
);

    rv_sys_pkg::word_t boot_pc;
    logic              go;
    logic              ebreak_hit;

    mem_access_if mem_if ();

    core_ctrl #(
        .num_regs (num_regs)
    ) ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .boot_pc      (boot_pc),
        .go           (go),
        .mem          (mem_if.ctrl),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .ebreak_hit   (ebreak_hit)
    );

    // single outstanding access to the external port
    bus_bridge bridge_i (
        .clk       (clk),
        .reset     (reset),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .acc       (mem_if.bridge),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_size  (mem_size)
    );

    run_cfg cfg_i (
        .clk        (clk),
        .reset      (reset),
        .boot_addr  (boot_addr),
        .retire     (retire_valid),
        .ebreak_hit (ebreak_hit),
        .boot_pc    (boot_pc),
        .go         (go),
        .halted     (halted),
        .instret    (instret)
    );

endmodule

//--- tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 16;
    // cycles allowed per expected retire
    localparam int retire_budget = 20;

    logic                  clk = 1'b0;
    logic                  reset;
    rv_sys_pkg::word_t     boot_addr;
    logic                  mem_ack;
    rv_sys_pkg::word_t     mem_rdata;
    logic                  mem_req;
    rv_sys_pkg::word_t     mem_addr;
    rv_sys_pkg::acc_size_t mem_size;
    logic                  retire_valid;
    rv_sys_pkg::word_t     retire_pc;
    rv_isa_pkg::reg_idx_t  retire_rd;
    rv_sys_pkg::word_t     retire_data;
    logic                  halted;
    rv_sys_pkg::word_t     instret;

    // sparse memory keyed by word-aligned address
    rv_sys_pkg::word_t    mem_words [rv_sys_pkg::word_t];
    // expected retire records in program order
    rv_sys_pkg::word_t    exp_pc [$];
    rv_isa_pkg::reg_idx_t exp_rd [$];
    rv_sys_pkg::word_t    exp_data [$];
    rv_sys_pkg::word_t    boot_val;
    rv_sys_pkg::word_t    exp_instret;

    logic [31:0] lfsr_state = 32'hd1a4;
    int          value_errors = 0;
    int          other_errors = 0;
    int          ret_idx = 0;
    bit          first_req_seen = 1'b0;
    bit          halt_seen = 1'b0;
    bit          run_started = 1'b0;
    logic        retire_prev = 1'b0;

    rv_core_top #(
        .num_regs (32)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .boot_addr    (boot_addr),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_size     (mem_size),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halted       (halted),
        .instret      (instret)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_word(input string name, input rv_sys_pkg::word_t exp,
                              input rv_sys_pkg::word_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error at %0d ns: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input rv_isa_pkg::reg_idx_t exp,
                             input rv_isa_pkg::reg_idx_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error at %0d ns: %s expected x%0d, actual x%0d", $time, name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("at %0d ns: %s", $time, what);
    endtask

    task automatic print_counts();
        $display("value mismatches: %0d, other failures: %0d", value_errors, other_errors);
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // two lfsr bits give 0 to 3 extra cycles
    task automatic draw_delay(output int cycles);
        cycles = 0;
        for (int i = 0; i < 2; i++) begin
            if (lfsr_state[31])
                cycles += (1 << i);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic rv_sys_pkg::word_t read_mem(input rv_sys_pkg::word_t addr,
                                                   input rv_sys_pkg::acc_size_t size);
        rv_sys_pkg::word_t aligned;
        rv_sys_pkg::word_t w;
        rv_sys_pkg::word_t r;
        aligned = {addr[31:2], 2'b00};
        // untouched words read back a pattern of their own address
        if (mem_words.exists(aligned))
            w = mem_words[aligned];
        else
            w = aligned ^ 32'h5eedc0de;
        r = w;
        // little endian byte lanes zero extended
        if (size == rv_sys_pkg::size_byte) begin
            case (addr[1:0])
                2'd0: r = {24'b0, w[7:0]};
                2'd1: r = {24'b0, w[15:8]};
                2'd2: r = {24'b0, w[23:16]};
                default: r = {24'b0, w[31:24]};
            endcase
        end
        return r;
    endfunction

    // b boot, m preload, r expected retire, h final instret
    task automatic load_cases();
        int                fd;
        int                c;
        int                n;
        logic [7:0]        ch;
        rv_sys_pkg::word_t a;
        rv_sys_pkg::word_t w;
        rv_sys_pkg::word_t d;
        fd = $fopen("rv_cases.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open rv_cases.txt");
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            ch = c[7:0];
            if (ch == "b") begin
                n = $fscanf(fd, "%h", boot_val);
                if (n != 1)
                    report_failure("malformed b record in rv_cases.txt");
            end else if (ch == "m") begin
                n = $fscanf(fd, "%h %h", a, w);
                if (n != 2)
                    report_failure("malformed m record in rv_cases.txt");
                mem_words[{a[31:2], 2'b00}] = w;
            end else if (ch == "r") begin
                n = $fscanf(fd, "%h %h %h", a, w, d);
                if (n != 3)
                    report_failure("malformed r record in rv_cases.txt");
                exp_pc.push_back(a);
                exp_rd.push_back(w[4:0]);
                exp_data.push_back(d);
            end else if (ch == "h") begin
                n = $fscanf(fd, "%h", exp_instret);
                if (n != 1)
                    report_failure("malformed h record in rv_cases.txt");
            end else if (ch == "#") begin
                // rest of the line is a comment
                while (c != -1 && c != 10)
                    c = $fgetc(fd);
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    // memory side of the four-phase handshake
    initial begin : mem_model
        int delay;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            if (!reset && mem_req && !mem_ack) begin
                draw_delay(delay);
                repeat (delay) @(posedge clk);
                mem_rdata <= read_mem(mem_addr, mem_size);
                mem_ack   <= 1'b1;
                @(posedge clk);
                // hold ack until the bridge lets go of req
                while (mem_req)
                    @(posedge clk);
                draw_delay(delay);
                repeat (delay) @(posedge clk);
                mem_ack <= 1'b0;
            end
        end
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin : retire_monitor
        bit is_last;
        if (reset) begin
            if (retire_valid !== 1'b0)
                report_failure("retire_valid not low during reset");
            if (halted !== 1'b0)
                report_failure("halted not low during reset");
            if (mem_req !== 1'b0)
                report_failure("mem_req not low during reset");
        end else begin
            if (mem_req && !first_req_seen) begin
                check_word("mem_addr", boot_val, mem_addr);
                first_req_seen = 1'b1;
            end
            if (mem_req && halt_seen)
                report_failure("mem_req raised after the core halted");
            if (retire_valid) begin
                if (retire_prev)
                    report_failure("retire_valid stayed high for more than one cycle");
                if (ret_idx >= exp_pc.size()) begin
                    report_failure("retire beyond the end of the expected list");
                end else begin
                    check_word("retire_pc", exp_pc[ret_idx], retire_pc);
                    check_reg("retire_rd", exp_rd[ret_idx], retire_rd);
                    check_word("retire_data", exp_data[ret_idx], retire_data);
                    // halted rises with the last retire which is the ebreak
                    is_last = (ret_idx == exp_pc.size() - 1);
                    if (halted !== is_last)
                        report_failure("halted does not match the ebreak retire");
                end
                ret_idx++;
            end else if (halted && !halt_seen) begin
                report_failure("halted rose without a retire");
            end
            if (halted)
                halt_seen = 1'b1;
            else if (halt_seen)
                report_failure("halted dropped before reset");
            retire_prev = retire_valid;
        end
    end

    // limit scales with the number of expected retires
    initial begin : watchdog
        wait (run_started);
        #(exp_pc.size() * retire_budget * clk_period);
        report_failure("watchdog expired, the core did not halt");
        print_counts();
        $display("Finished with errors");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        boot_addr = rv_sys_pkg::boot_default;
        boot_val  = rv_sys_pkg::boot_default;
        load_cases();
        @(posedge clk);
        boot_addr <= boot_val;
        repeat (reset_cycles - 1) @(posedge clk);
        reset <= 1'b0;
        run_started = 1'b1;
        wait (halt_seen);
        // idle window to catch stray accesses after halt
        repeat (8) @(posedge clk);
        if (ret_idx < exp_pc.size())
            report_failure("fewer retires than expected before halt");
        if (halted !== 1'b1)
            report_failure("halted low at the end of the run");
        check_word("instret", exp_instret, instret);
        print_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- rv_cases.txt
# b boot_addr | m addr word | r pc rd data | h instret
# all values hex, text after # is ignored
b 00000200
m 00000200 123450b7  # lui   x1, 0x12345
m 00000204 67808093  # addi  x1, x1, 0x678
m 00000208 fff00113  # addi  x2, x0, -1
m 0000020c 002081b3  # add   x3, x1, x2
m 00000210 00001217  # auipc x4, 0x1
m 00000214 00500013  # addi  x0, x0, 5
m 00000218 001002b3  # add   x5, x0, x1
m 0000021c 0100036f  # jal   x6, +16
m 0000022c 23000393  # addi  x7, x0, 0x230
m 00000230 01138467  # jalr  x8, 0x11(x7)
m 00000240 000014b7  # lui   x9, 0x1
m 00000244 0044a503  # lw    x10, 4(x9)
m 00000248 0064c583  # lbu   x11, 6(x9)
m 0000024c fff4c603  # lbu   x12, -1(x9)
m 00000250 0004a683  # lw    x13, 0(x9)
m 00000254 00b50733  # add   x14, x10, x11
m 00000258 0000000b  # unknown opcode
m 0000025c 00100073  # ebreak
m 00000ffc e1223344
m 00001000 cafef00d
m 00001004 8899aabb
r 00000200 01 12345000
r 00000204 01 12345678
r 00000208 02 ffffffff
r 0000020c 03 12345677
r 00000210 04 00001210
r 00000214 00 00000005
r 00000218 05 12345678
r 0000021c 06 00000220
r 0000022c 07 00000230
r 00000230 08 00000234
r 00000240 09 00001000
r 00000244 0a 8899aabb
r 00000248 0b 00000099
r 0000024c 0c 000000e1
r 00000250 0d cafef00d
r 00000254 0e 8899ab54
r 00000258 00 00000000
r 0000025c 00 00000000
h 00000012

//--- compile.f
rv_sys_pkg.sv
rv_isa_pkg.sv
mem_access_if.sv
inst_decode.sv
regfile.sv
core_ctrl.sv
bus_bridge.sv
run_cfg.sv
rv_core_top.sv
tb_rv_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps
TOP       = tb_rv_core
FILELIST  = compile.f
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
